/* include/alloc_ref_model.svh */
`ifndef ALLOC_REF_MODEL_SVH
`define ALLOC_REF_MODEL_SVH

import noc_alloc_pkg::*;

// pointer and last winner of every arbiter, -1 means no grant
int ref_vc1_ptr [num_pv];
int ref_vc1_win [num_pv];
int ref_vc2_ptr [num_pv];
int ref_vc2_win [num_pv];
// switch stages, index 0 is non-speculative and 1 speculative
int ref_sw_in_ptr  [2][num_ports];
int ref_sw_in_win  [2][num_ports];
int ref_sw_out_ptr [2][num_ports];
int ref_sw_out_win [2][num_ports];

ovc_req_all_t    exp_granted_ovc_num;
pv_vec_t         exp_ovc_allocated;
pv_vec_t         exp_ivc_got_ovc;
pv_vec_t         exp_ivc_sw_grant;
dest_grant_all_t exp_granted_dest_port;
dest_grant_all_t exp_nonspec_granted_dest_port;
dest_grant_all_t exp_spec_granted_dest_port;
port_vec_t       exp_any_ivc_sw_grant;

function automatic int ref_rr(input int width, input logic [7:0] req, input int ptr);
    int idx;
    for (int off = 0; off < width; off++) begin
        idx = (ptr + off) % width;
        if (req[idx]) return idx;
    end
    return -1;
endfunction

// one separable switch allocator
function automatic void ref_sw_stage(input int s, input pv_vec_t req, input dest_all_t dest,
                                     output pv_vec_t ivc_g, output dest_grant_all_t dg);
    dest_sel_t wdest [num_ports];
    dest_sel_t oreq;
    int        ip;
    int        w;
    ivc_g = '0;
    dg    = '0;
    for (int p = 0; p < num_ports; p++) begin
        w = ref_rr(num_vcs, 8'(req[p*num_vcs +: num_vcs]), ref_sw_in_ptr[s][p]);
        ref_sw_in_win[s][p] = w;
        wdest[p] = (w >= 0) ? dest[p * num_vcs + w] : '0;
    end
    for (int q = 0; q < num_ports; q++) begin
        for (int r = 0; r < num_dest; r++) begin
            ip = (r < q) ? r : r + 1;
            oreq[r] = wdest[ip][(q < ip) ? q : q - 1];
        end
        w = ref_rr(num_dest, 8'(oreq), ref_sw_out_ptr[s][q]);
        ref_sw_out_win[s][q] = w;
        if (w >= 0) begin
            ip = (w < q) ? w : w + 1;
            dg[ip][(q < ip) ? q : q - 1] = 1'b1;
            ivc_g[ip * num_vcs + ref_sw_in_win[s][ip]] = 1'b1;
        end
    end
endfunction

// every dut output from the inputs and the current pointers
function automatic void ref_compute(input dest_all_t dest, input ovc_req_all_t ovc_req,
                                    input pv_vec_t req, input pv_vec_t assigned,
                                    input pv_vec_t not_full);
    pv_vec_t         ns_ivc;
    pv_vec_t         sp_ivc;
    dest_grant_all_t ns_dg;
    dest_grant_all_t sp_dg;
    port_vec_t       ns_out;
    logic [7:0]      sreq;
    vc_vec_t         sp_vc;
    int              ip;
    int              i;
    int              w;
    exp_granted_ovc_num = '0;
    exp_ovc_allocated   = '0;
    for (int n = 0; n < num_pv; n++) begin
        ref_vc1_win[n] = ref_rr(num_vcs, 8'(ovc_req[n]), ref_vc1_ptr[n]);
    end
    for (int o = 0; o < num_pv; o++) begin
        sreq = '0;
        for (int j = 0; j < num_dest * num_vcs; j++) begin
            ip = (j / num_vcs < o / num_vcs) ? j / num_vcs : j / num_vcs + 1;
            i  = ip * num_vcs + j % num_vcs;
            sreq[j] = (ref_vc1_win[i] == o % num_vcs)
                      && dest[i][(o / num_vcs < ip) ? o / num_vcs : o / num_vcs - 1];
        end
        w = ref_rr(num_dest * num_vcs, sreq, ref_vc2_ptr[o]);
        ref_vc2_win[o] = w;
        if (w >= 0) begin
            ip = (w / num_vcs < o / num_vcs) ? w / num_vcs : w / num_vcs + 1;
            exp_ovc_allocated[o] = 1'b1;
            exp_granted_ovc_num[ip * num_vcs + w % num_vcs][o % num_vcs] = 1'b1;
        end
    end
    for (int n = 0; n < num_pv; n++) begin
        exp_ivc_got_ovc[n] = |exp_granted_ovc_num[n];
    end
    ref_sw_stage(0, req & assigned & not_full, dest, ns_ivc, ns_dg);
    ref_sw_stage(1, req & ~assigned, dest, sp_ivc, sp_dg);
    ns_out = '0;
    for (int p = 0; p < num_ports; p++) begin
        for (int k = 0; k < num_dest; k++) begin
            if (ns_dg[p][k]) ns_out[(k < p) ? k : k + 1] = 1'b1;
        end
    end
    exp_spec_granted_dest_port = '0;
    for (int p = 0; p < num_ports; p++) begin
        sp_vc = sp_ivc[p*num_vcs +: num_vcs];
        if (!(|ns_dg[p]) && |(sp_vc & exp_ivc_got_ovc[p*num_vcs +: num_vcs])) begin
            for (int k = 0; k < num_dest; k++) begin
                exp_spec_granted_dest_port[p][k] = sp_dg[p][k] & !ns_out[(k < p) ? k : k + 1];
            end
        end
        if (!(|exp_spec_granted_dest_port[p])) sp_vc = '0;
        exp_ivc_sw_grant[p*num_vcs +: num_vcs] = ns_ivc[p*num_vcs +: num_vcs] | sp_vc;
        exp_any_ivc_sw_grant[p] = |ns_dg[p] || |exp_spec_granted_dest_port[p];
    end
    exp_nonspec_granted_dest_port = ns_dg;
    exp_granted_dest_port = ns_dg | exp_spec_granted_dest_port;
endfunction

// pointer update at a rising edge, clear on reset
function automatic void ref_advance(input logic rst);
    for (int n = 0; n < num_pv; n++) begin
        if (rst) ref_vc1_ptr[n] = 0;
        else if (ref_vc1_win[n] >= 0) ref_vc1_ptr[n] = (ref_vc1_win[n] + 1) % num_vcs;
        if (rst) ref_vc2_ptr[n] = 0;
        else if (ref_vc2_win[n] >= 0) ref_vc2_ptr[n] = (ref_vc2_win[n] + 1) % (num_dest * num_vcs);
    end
    for (int s = 0; s < 2; s++) begin
        for (int p = 0; p < num_ports; p++) begin
            if (rst) ref_sw_in_ptr[s][p] = 0;
            else if (ref_sw_in_win[s][p] >= 0)
                ref_sw_in_ptr[s][p] = (ref_sw_in_win[s][p] + 1) % num_vcs;
            if (rst) ref_sw_out_ptr[s][p] = 0;
            else if (ref_sw_out_win[s][p] >= 0)
                ref_sw_out_ptr[s][p] = (ref_sw_out_win[s][p] + 1) % num_dest;
        end
    end
endfunction

`endif

/* bench/tb_baseline_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_baseline_alloc;

`include "alloc_ref_model.svh"

    localparam int reset_cycles  = 8;
    localparam int random_cycles = 2000;
    // reset, directed tests and random traffic, with headroom
    localparam int max_cycles    = 2500;

    logic            clk;
    logic            arst_n;
    dest_all_t       dest_port;
    ovc_req_all_t    masked_ovc_request;
    pv_vec_t         ivc_request;
    pv_vec_t         ovc_is_assigned;
    pv_vec_t         assigned_ovc_not_full;
    pv_vec_t         ovc_allocated;
    ovc_req_all_t    granted_ovc_num;
    pv_vec_t         ivc_got_ovc;
    pv_vec_t         ivc_sw_grant;
    dest_grant_all_t granted_dest_port;
    dest_grant_all_t nonspec_granted_dest_port;
    dest_grant_all_t spec_granted_dest_port;
    port_vec_t       any_ivc_sw_grant;

    logic [31:0] rng_state;
    int          cycle_count;
    int          compare_count;

    baseline_alloc_top u_dut (
        .clk                       (clk),
        .arst_n                    (arst_n),
        .dest_port                 (dest_port),
        .masked_ovc_request        (masked_ovc_request),
        .ivc_request               (ivc_request),
        .ovc_is_assigned           (ovc_is_assigned),
        .assigned_ovc_not_full     (assigned_ovc_not_full),
        .ovc_allocated             (ovc_allocated),
        .granted_ovc_num           (granted_ovc_num),
        .ivc_got_ovc               (ivc_got_ovc),
        .ivc_sw_grant              (ivc_sw_grant),
        .granted_dest_port         (granted_dest_port),
        .nonspec_granted_dest_port (nonspec_granted_dest_port),
        .spec_granted_dest_port    (spec_granted_dest_port),
        .any_ivc_sw_grant          (any_ivc_sw_grant)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("ERR %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic clear_inputs();
        dest_port             = '0;
        masked_ovc_request    = '0;
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
    endtask

    // inputs change shortly after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_random();
        for (int i = 0; i < num_pv; i++) begin
            rng_state = lcg_step(rng_state);
            dest_port[i] = 4'b0001 << rng_state[29:28];
            masked_ovc_request[i] = rng_state[31:30];
        end
        rng_state = lcg_step(rng_state);
        ivc_request = rng_state[31:22];
        rng_state = lcg_step(rng_state);
        ovc_is_assigned = rng_state[31:22];
        rng_state = lcg_step(rng_state);
        // mostly not full so the non-speculative side stays busy
        assigned_ovc_not_full = rng_state[31:22] | rng_state[21:12];
    endtask

    task automatic check_all_idle();
        expect_equal("ovc_allocated", 64'(ovc_allocated), 64'(0));
        expect_equal("granted_ovc_num", 64'(granted_ovc_num), 64'(0));
        expect_equal("ivc_got_ovc", 64'(ivc_got_ovc), 64'(0));
        expect_equal("ivc_sw_grant", 64'(ivc_sw_grant), 64'(0));
        expect_equal("granted_dest_port", 64'(granted_dest_port), 64'(0));
        expect_equal("nonspec_granted_dest_port", 64'(nonspec_granted_dest_port), 64'(0));
        expect_equal("spec_granted_dest_port", 64'(spec_granted_dest_port), 64'(0));
        expect_equal("any_ivc_sw_grant", 64'(any_ivc_sw_grant), 64'(0));
    endtask

    // model pointers move at the same edge as the dut arbiters
    always @(posedge clk) begin
        ref_advance(!arst_n);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
                                        max_cycles));
        end
    end

    // outputs have settled well before the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            ref_compute(dest_port, masked_ovc_request, ivc_request, ovc_is_assigned,
                        assigned_ovc_not_full);
            expect_equal("ovc_allocated", 64'(ovc_allocated), 64'(exp_ovc_allocated));
            expect_equal("granted_ovc_num", 64'(granted_ovc_num), 64'(exp_granted_ovc_num));
            expect_equal("ivc_got_ovc", 64'(ivc_got_ovc), 64'(exp_ivc_got_ovc));
            expect_equal("ivc_sw_grant", 64'(ivc_sw_grant), 64'(exp_ivc_sw_grant));
            expect_equal("granted_dest_port", 64'(granted_dest_port),
                         64'(exp_granted_dest_port));
            expect_equal("nonspec_granted_dest_port", 64'(nonspec_granted_dest_port),
                         64'(exp_nonspec_granted_dest_port));
            expect_equal("spec_granted_dest_port", 64'(spec_granted_dest_port),
                         64'(exp_spec_granted_dest_port));
            expect_equal("any_ivc_sw_grant", 64'(any_ivc_sw_grant),
                         64'(exp_any_ivc_sw_grant));
            expect_equal("granted_dest_port vs merge", 64'(granted_dest_port),
                         64'(nonspec_granted_dest_port | spec_granted_dest_port));
            for (int p = 0; p < num_ports; p++) begin
                expect_equal($sformatf("any_ivc_sw_grant[%0d]", p), 64'(any_ivc_sw_grant[p]),
                             64'(|ivc_sw_grant[p*num_vcs +: num_vcs]));
            end
            compare_count++;
        end
    end

    initial begin
        rng_state     = 32'h89818cda;
        cycle_count   = 0;
        compare_count = 0;
        arst_n        = 1'b0;
        clear_inputs();
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // idle after reset
        repeat (2) begin
            @(negedge clk);
            check_all_idle();
        end

        // ivc 0 and ivc 2 both want output vc 0 of port 2
        next_cycle();
        dest_port[0]          = 4'b0010;
        dest_port[2]          = 4'b0010;
        masked_ovc_request[0] = 2'b01;
        masked_ovc_request[2] = 2'b01;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            expect_equal("ovc_allocated", 64'(ovc_allocated), 64'(10'b1 << 4));
            expect_equal("granted_ovc_num[0]", 64'(granted_ovc_num[0]),
                         64'((c % 2 == 0) ? 2'b01 : 2'b00));
            expect_equal("granted_ovc_num[2]", 64'(granted_ovc_num[2]),
                         64'((c % 2 == 1) ? 2'b01 : 2'b00));
            @(posedge clk);
        end

        // assigned ivc 0 and speculative ivc 2 both target port 2
        next_cycle();
        clear_inputs();
        dest_port[0]          = 4'b0010;
        dest_port[2]          = 4'b0010;
        masked_ovc_request[2] = 2'b01;
        ivc_request           = 10'b00_0000_0101;
        ovc_is_assigned       = 10'b00_0000_0001;
        assigned_ovc_not_full = '1;
        @(negedge clk);
        expect_equal("nonspec_granted_dest_port[0]", 64'(nonspec_granted_dest_port[0]),
                     64'(4'b0010));
        expect_equal("spec_granted_dest_port[1]", 64'(spec_granted_dest_port[1]), 64'(0));
        expect_equal("ivc_sw_grant", 64'(ivc_sw_grant), 64'(10'b00_0000_0001));
        next_cycle();
        assigned_ovc_not_full = '0;
        @(negedge clk);
        expect_equal("nonspec_granted_dest_port", 64'(nonspec_granted_dest_port), 64'(0));
        expect_equal("ivc_sw_grant[0]", 64'(ivc_sw_grant[0]), 64'(0));

        // speculative ivc 2 first loses output vc 4 to ivc 0, then wins it
        // the pointer of output vc 4 sits just past ivc 2 at this point
        next_cycle();
        clear_inputs();
        dest_port[0]          = 4'b0010;
        dest_port[2]          = 4'b0010;
        masked_ovc_request[0] = 2'b01;
        masked_ovc_request[2] = 2'b01;
        ivc_request           = 10'b00_0000_0100;
        for (int c = 0; c < 2; c++) begin
            @(negedge clk);
            expect_equal("ivc_got_ovc[2]", 64'(ivc_got_ovc[2]), 64'(c));
            expect_equal("ivc_sw_grant[2]", 64'(ivc_sw_grant[2]), 64'(c));
            expect_equal("spec_granted_dest_port[1]", 64'(spec_granted_dest_port[1]),
                         64'((c == 1) ? 4'b0010 : 4'b0000));
            @(posedge clk);
        end

        // lone speculative ivc 7 wins both allocators
        next_cycle();
        clear_inputs();
        dest_port[7]          = 4'b0001;
        masked_ovc_request[7] = 2'b10;
        ivc_request           = 10'b00_1000_0000;
        @(negedge clk);
        expect_equal("granted_ovc_num[7]", 64'(granted_ovc_num[7]), 64'(2'b10));
        expect_equal("ivc_sw_grant", 64'(ivc_sw_grant), 64'(10'b00_1000_0000));
        expect_equal("spec_granted_dest_port[3]", 64'(spec_granted_dest_port[3]),
                     64'(4'b0001));
        expect_equal("any_ivc_sw_grant", 64'(any_ivc_sw_grant), 64'(5'b01000));

        repeat (random_cycles) begin
            next_cycle();
            drive_random();
        end
        @(negedge clk);
        #1;

        if (compare_count > random_cycles) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("only %0d cycles were compared against the model",
                                        compare_count));
        end
    end

endmodule

`default_nettype wire

/* logic/baseline_alloc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module baseline_alloc_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  noc_alloc_pkg::dest_all_t       dest_port,
    input  noc_alloc_pkg::ovc_req_all_t    masked_ovc_request,
    input  noc_alloc_pkg::pv_vec_t         ivc_request,
    input  noc_alloc_pkg::pv_vec_t         ovc_is_assigned,
    input  noc_alloc_pkg::pv_vec_t         assigned_ovc_not_full,
    output noc_alloc_pkg::pv_vec_t         ovc_allocated,
    output noc_alloc_pkg::ovc_req_all_t    granted_ovc_num,
    output noc_alloc_pkg::pv_vec_t         ivc_got_ovc,
    output noc_alloc_pkg::pv_vec_t         ivc_sw_grant,
    output noc_alloc_pkg::dest_grant_all_t granted_dest_port,
    output noc_alloc_pkg::dest_grant_all_t nonspec_granted_dest_port,
    output noc_alloc_pkg::dest_grant_all_t spec_granted_dest_port,
    output noc_alloc_pkg::port_vec_t       any_ivc_sw_grant
);

    vc_alloc u_vc_alloc (
        .clk                (clk),
        .arst_n             (arst_n),
        .dest_port          (dest_port),
        .masked_ovc_request (masked_ovc_request),
        .ovc_allocated      (ovc_allocated),
        .granted_ovc_num    (granted_ovc_num),
        .ivc_got_ovc        (ivc_got_ovc)
    );

    // vc grants of this cycle validate the speculative switch grants
    spec_sw_alloc u_sw_alloc (
        .clk                       (clk),
        .arst_n                    (arst_n),
        .ivc_request               (ivc_request),
        .ovc_is_assigned           (ovc_is_assigned),
        .assigned_ovc_not_full     (assigned_ovc_not_full),
        .ivc_got_ovc               (ivc_got_ovc),
        .dest_port                 (dest_port),
        .ivc_sw_grant              (ivc_sw_grant),
        .granted_dest_port         (granted_dest_port),
        .nonspec_granted_dest_port (nonspec_granted_dest_port),
        .spec_granted_dest_port    (spec_granted_dest_port),
        .any_ivc_sw_grant          (any_ivc_sw_grant)
    );

endmodule

`default_nettype wire

/* logic/noc_alloc_pkg.sv */
`default_nettype none

package noc_alloc_pkg;

    // router geometry
    localparam int num_ports = 5;
    localparam int num_vcs   = 2;
    // a port never routes back to itself
    localparam int num_dest  = num_ports - 1;
    localparam int num_pv    = num_ports * num_vcs;

    // one bit per port
    typedef logic [num_ports-1:0] port_vec_t;

    // one bit per vc of a single port
    typedef logic [num_vcs-1:0] vc_vec_t;

    // one bit per vc in the router, index is port * num_vcs + vc
    typedef logic [num_pv-1:0] pv_vec_t;

    // one-hot destination relative to the input port
    // bit k is port k below the input port, port k+1 from it upward
    typedef logic [num_dest-1:0] dest_sel_t;

    // destination of every input vc
    typedef dest_sel_t [num_pv-1:0] dest_all_t;

    // acceptable output vcs, or the granted output vc, per input vc
    typedef vc_vec_t [num_pv-1:0] ovc_req_all_t;

    // granted destination per input port
    typedef dest_sel_t [num_ports-1:0] dest_grant_all_t;

endpackage

`default_nettype wire

/* logic/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [width-1:0] request,
    output logic [width-1:0] grant,
    output logic             any_grant
);
    localparam int ptr_w = $clog2(width);

    logic [ptr_w-1:0] pointer;
    logic [ptr_w-1:0] winner;

    assign any_grant = |request;

    // scan from the farthest offset back, so the nearest request at or
    // after the pointer is the last one written
    always_comb begin
        int idx;
        winner = pointer;
        for (int off = width - 1; off >= 0; off--) begin
            idx = (int'(pointer) + off) % width;
            if (request[idx]) begin
                winner = ptr_w'(idx);
            end
        end
        grant = any_grant ? (width'(1) << winner) : '0;
    end

    // priority moves just past the winner
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pointer <= '0;
        end else if (any_grant) begin
            pointer <= (winner == ptr_w'(width - 1)) ? '0 : winner + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((grant & ~request) == '0) && (any_grant == |grant));

endmodule

`default_nettype wire

/* logic/spec_sw_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module spec_sw_alloc (
    input  logic                           clk,
    input  logic                           arst_n,
    input  noc_alloc_pkg::pv_vec_t         ivc_request,
    input  noc_alloc_pkg::pv_vec_t         ovc_is_assigned,
    input  noc_alloc_pkg::pv_vec_t         assigned_ovc_not_full,
    input  noc_alloc_pkg::pv_vec_t         ivc_got_ovc,
    input  noc_alloc_pkg::dest_all_t       dest_port,
    output noc_alloc_pkg::pv_vec_t         ivc_sw_grant,
    output noc_alloc_pkg::dest_grant_all_t granted_dest_port,
    output noc_alloc_pkg::dest_grant_all_t nonspec_granted_dest_port,
    output noc_alloc_pkg::dest_grant_all_t spec_granted_dest_port,
    output noc_alloc_pkg::port_vec_t       any_ivc_sw_grant
);
    import noc_alloc_pkg::*;

    pv_vec_t         nonspec_request;
    pv_vec_t         spec_request;
    pv_vec_t         nonspec_ivc_granted;
    pv_vec_t         spec_ivc_granted;
    dest_grant_all_t spec_dest_pre;
    port_vec_t       nonspec_inport;
    port_vec_t       nonspec_outport;
    port_vec_t       nonspec_outport_claimed;
    port_vec_t       spec_inport;
    port_vec_t       spec_accepted;
    port_vec_t       spec_outport_taken;

    // vc already held and room downstream
    assign nonspec_request = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
    // still waiting on vc allocation
    assign spec_request    = ivc_request & ~ovc_is_assigned;

    sw_alloc_stage u_nonspec (
        .clk               (clk),
        .arst_n            (arst_n),
        .ivc_request       (nonspec_request),
        .dest_port         (dest_port),
        .ivc_granted       (nonspec_ivc_granted),
        .granted_dest_port (nonspec_granted_dest_port),
        .inport_granted    (nonspec_inport),
        .outport_granted   (nonspec_outport)
    );

    sw_alloc_stage u_spec (
        .clk               (clk),
        .arst_n            (arst_n),
        .ivc_request       (spec_request),
        .dest_port         (dest_port),
        .ivc_granted       (spec_ivc_granted),
        .granted_dest_port (spec_dest_pre),
        .inport_granted    (spec_inport),
        .outport_granted   ()
    );

    always_comb begin
        dest_sel_t taken;
        vc_vec_t   spec_vc;
        int        q;
        spec_outport_taken      = '0;
        nonspec_outport_claimed = '0;
        for (int p = 0; p < num_ports; p++) begin
            // outputs claimed non-speculatively, seen from port p
            for (int k = 0; k < num_dest; k++) begin
                q = (k < p) ? k : k + 1;
                taken[k] = nonspec_outport[q];
            end
            spec_vc = spec_ivc_granted[p*num_vcs +: num_vcs];
            // speculation only counts if the same vc won an output vc
            if (spec_inport[p] && !nonspec_inport[p]
                && |(spec_vc & ivc_got_ovc[p*num_vcs +: num_vcs])) begin
                spec_granted_dest_port[p] = spec_dest_pre[p] & ~taken;
            end else begin
                spec_granted_dest_port[p] = '0;
            end
            spec_accepted[p] = |spec_granted_dest_port[p];
            ivc_sw_grant[p*num_vcs +: num_vcs] = nonspec_ivc_granted[p*num_vcs +: num_vcs]
                                                 | (spec_accepted[p] ? spec_vc : '0);
            for (int k = 0; k < num_dest; k++) begin
                q = (k < p) ? k : k + 1;
                if (spec_granted_dest_port[p][k]) begin
                    spec_outport_taken[q] = 1'b1;
                end
                // non-speculative claims rebuilt from the per-input grants
                if (nonspec_granted_dest_port[p][k]) begin
                    nonspec_outport_claimed[q] = 1'b1;
                end
            end
        end
    end

    assign granted_dest_port = nonspec_granted_dest_port | spec_granted_dest_port;
    assign any_ivc_sw_grant  = nonspec_inport | spec_accepted;

    // no output port is claimed by both allocators at once
    assert property (@(posedge clk) disable iff (!arst_n)
        (nonspec_outport_claimed == nonspec_outport)
        && ((nonspec_outport_claimed & spec_outport_taken) == '0));

endmodule

`default_nettype wire

/* logic/sw_alloc_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module sw_alloc_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  noc_alloc_pkg::pv_vec_t         ivc_request,
    input  noc_alloc_pkg::dest_all_t       dest_port,
    output noc_alloc_pkg::pv_vec_t         ivc_granted,
    output noc_alloc_pkg::dest_grant_all_t granted_dest_port,
    output noc_alloc_pkg::port_vec_t       inport_granted,
    output noc_alloc_pkg::port_vec_t       outport_granted
);
    import noc_alloc_pkg::*;

    vc_vec_t   in_winner [num_ports];
    dest_sel_t win_dest  [num_ports];
    dest_sel_t out_req   [num_ports];
    dest_sel_t out_grant [num_ports];
    logic      out_any   [num_ports];

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        // input side, over the vcs of port p
        rr_arbiter #(.width(num_vcs)) u_in_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (ivc_request[p*num_vcs +: num_vcs]),
            .grant     (in_winner[p]),
            .any_grant ()
        );

        // output side, over the other four input ports
        rr_arbiter #(.width(num_dest)) u_out_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (out_req[p]),
            .grant     (out_grant[p]),
            .any_grant (out_any[p])
        );
    end

    // winning vc of each input requests its own destination
    always_comb begin
        int ip;
        int k;
        for (int p = 0; p < num_ports; p++) begin
            win_dest[p] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (in_winner[p][v]) begin
                    win_dest[p] = win_dest[p] | dest_port[p * num_vcs + v];
                end
            end
        end
        for (int q = 0; q < num_ports; q++) begin
            for (int r = 0; r < num_dest; r++) begin
                ip = (r < q) ? r : r + 1;
                k  = (q < ip) ? q : q - 1;
                out_req[q][r] = win_dest[ip][k];
            end
        end
    end

    // map output grants back to the relative view of each input
    always_comb begin
        int q;
        int r;
        for (int p = 0; p < num_ports; p++) begin
            for (int k = 0; k < num_dest; k++) begin
                q = (k < p) ? k : k + 1;
                r = (p < q) ? p : p - 1;
                granted_dest_port[p][k] = out_grant[q][r];
            end
            inport_granted[p]  = |granted_dest_port[p];
            outport_granted[p] = out_any[p];
            ivc_granted[p*num_vcs +: num_vcs] = inport_granted[p] ? in_winner[p] : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/vc_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module vc_alloc (
    input  logic                        clk,
    input  logic                        arst_n,
    input  noc_alloc_pkg::dest_all_t    dest_port,
    input  noc_alloc_pkg::ovc_req_all_t masked_ovc_request,
    output noc_alloc_pkg::pv_vec_t      ovc_allocated,
    output noc_alloc_pkg::ovc_req_all_t granted_ovc_num,
    output noc_alloc_pkg::pv_vec_t      ivc_got_ovc
);
    import noc_alloc_pkg::*;

    localparam int src_w = num_dest * num_vcs;

    vc_vec_t          first_grant  [num_pv];
    logic [src_w-1:0] second_req   [num_pv];
    logic [src_w-1:0] second_grant [num_pv];
    logic             second_any   [num_pv];

    // stage one: each input vc picks one of its acceptable output vcs
    for (genvar i = 0; i < num_pv; i++) begin : g_ivc
        rr_arbiter #(.width(num_vcs)) u_first_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (masked_ovc_request[i]),
            .grant     (first_grant[i]),
            .any_grant ()
        );
    end

    // stage two: each output vc picks among vcs of the other four ports
    for (genvar o = 0; o < num_pv; o++) begin : g_ovc
        rr_arbiter #(.width(src_w)) u_second_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (second_req[o]),
            .grant     (second_grant[o]),
            .any_grant (second_any[o])
        );
    end

    // steer each stage-one winner to its destination port
    // j counts source vcs of the ports other than op
    always_comb begin
        int op;
        int ip;
        int k;
        int i;
        for (int o = 0; o < num_pv; o++) begin
            op = o / num_vcs;
            for (int j = 0; j < src_w; j++) begin
                ip = (j / num_vcs < op) ? j / num_vcs : j / num_vcs + 1;
                k  = (op < ip) ? op : op - 1;
                i  = ip * num_vcs + j % num_vcs;
                second_req[o][j] = first_grant[i][o % num_vcs] & dest_port[i][k];
            end
        end
    end

    // fold the stage-two grants back onto the input vcs
    always_comb begin
        int op;
        int ip;
        granted_ovc_num = '0;
        for (int o = 0; o < num_pv; o++) begin
            op = o / num_vcs;
            ovc_allocated[o] = second_any[o];
            for (int j = 0; j < src_w; j++) begin
                ip = (j / num_vcs < op) ? j / num_vcs : j / num_vcs + 1;
                if (second_grant[o][j]) begin
                    granted_ovc_num[ip * num_vcs + j % num_vcs][o % num_vcs] = 1'b1;
                end
            end
        end
        for (int i = 0; i < num_pv; i++) begin
            ivc_got_ovc[i] = |granted_ovc_num[i];
        end
    end

    // each allocated output vc lands on exactly one input vc
    assert property (@(posedge clk) disable iff (!arst_n)
        ($countones(granted_ovc_num) == $countones(ovc_allocated))
        && ($countones(ivc_got_ovc) == $countones(ovc_allocated)));

endmodule

`default_nettype wire

/* noc_alloc.f */
+incdir+include
logic/noc_alloc_pkg.sv
logic/rr_arbiter.sv
logic/vc_alloc.sv
logic/sw_alloc_stage.sv
logic/spec_sw_alloc.sv
logic/baseline_alloc_top.sv
bench/tb_baseline_alloc.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module tb_baseline_alloc \
    -f noc_alloc.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -qx "STATUS: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
